// File: hw/isa_pkg.sv
package isa_pkg;

  // opcode field of a 32-bit instruction word
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;

  // major opcodes the predictor has to recognize
  // anything else decodes as a plain instruction
  typedef enum logic [5:0] {
    // jump group: jmp, jsr, ret, jsr_coroutine
    JSR_GRP  = 6'h1a,
    // pc-relative unconditional
    BR_INST  = 6'h30,
    BSR_INST = 6'h34,
    // integer conditional branches
    BLBC_INST = 6'h38,
    BEQ_INST  = 6'h39,
    BLT_INST  = 6'h3a,
    BLE_INST  = 6'h3b,
    BLBS_INST = 6'h3c,
    BNE_INST  = 6'h3d,
    BGE_INST  = 6'h3e,
    BGT_INST  = 6'h3f
  } opcode_e;

  // result of classifying one fetched word
  typedef enum logic [1:0] {
    BR_NONE   = 2'd0,
    // direction comes from the bht
    BR_COND   = 2'd1,
    // always taken, target from the btb
    BR_UNCOND = 2'd2
  } branch_class_e;

endpackage

// File: hw/frontend_pkg.sv
package frontend_pkg;

  // lanes fetched per cycle, pc and pc+4
  localparam int FETCH_WIDTH = 2;

  // one slot of the fetch queue
  typedef struct packed {
    logic [63:0] pc;
    logic [31:0] instr;
    // set when the predictor steered fetch away after this word
    logic        predicted_taken;
  } fetch_entry_t;

  // two-bit saturating direction counter
  // msb alone gives the predicted direction
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } bht_state_e;

  // counters start weakly not taken
  // one taken resolve is enough to flip them
  localparam bht_state_e BHT_RESET_STATE = WEAK_NT;

endpackage

// File: hw/fetch_bundle_if.sv
`timescale 1ns/1ps

// predicted bundle from the prediction stage into the queue,
// freed slots flowing back the other way
interface fetch_bundle_if;

  // lane 1 is only valid behind a not-taken lane 0
  logic [frontend_pkg::FETCH_WIDTH-1:0] lane_valid;
  frontend_pkg::fetch_entry_t [frontend_pkg::FETCH_WIDTH-1:0] lane_entry;

  // slots freed by the queue this cycle, one per dequeued entry
  logic [1:0] credit_return;

  // predictor drives the lanes, pc stage only reads them
  modport pred_side (
    output lane_valid,
    output lane_entry,
    input  credit_return
  );

  modport queue_side (
    input  lane_valid,
    input  lane_entry,
    output credit_return
  );

endinterface

// File: hw/fetch_pc_stage.sv
`timescale 1ns/1ps

module fetch_pc_stage #(
  parameter int          QUEUE_DEPTH = 8,
  parameter logic [63:0] RESET_PC    = 64'h0
) (
  input  logic             clock,
  input  logic             reset,
  input  logic [63:0]      next_pc_pred,
  input  logic             redirect_valid,
  input  logic [63:0]      redirect_pc,
  fetch_bundle_if.pred_side pred,
  output logic [63:0]      fetch_pc,
  output logic             fetch_enable
);

  // one spare bit so an over-return shows up as a value above depth
  localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1) + 1;

  logic [63:0]         pc_q;
  logic [CREDIT_W-1:0] credits;
  logic [CREDIT_W-1:0] sent;

  // memory address comes straight off the register
  assign fetch_pc = pc_q;

  // a full bundle needs a slot per lane
  assign fetch_enable = credits >= CREDIT_W'(frontend_pkg::FETCH_WIDTH);

  // lanes that actually left the predictor this cycle
  always_comb begin
    sent = '0;
    for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
      sent = sent + CREDIT_W'(pred.lane_valid[i]);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q    <= RESET_PC;
      credits <= CREDIT_W'(QUEUE_DEPTH);
    end else if (redirect_valid) begin
      // rollback empties the queue, so every slot is free again
      pc_q    <= redirect_pc;
      credits <= CREDIT_W'(QUEUE_DEPTH);
    end else begin
      // hold pc while the queue cannot take a bundle
      if (fetch_enable) begin
        pc_q <= next_pc_pred;
      end
      credits <= credits - sent + CREDIT_W'(pred.credit_return);
    end
  end

  // queue never hands back more slots than it has
  a_credit_bound: assert property (
    @(posedge clock) disable iff (reset)
    credits <= CREDIT_W'(QUEUE_DEPTH)
  ) else $error("fetch credit count above queue depth");

  // btb targets and redirect targets must keep word alignment
  a_pc_aligned: assert property (
    @(posedge clock) disable iff (reset)
    pc_q[1:0] == 2'b00
  ) else $error("fetch pc not word aligned");

endmodule

// File: hw/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
  parameter int BHT_INDEX_BITS = 4
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [63:0] fetch_pc,
  input  logic        fetch_enable,
  input  logic [frontend_pkg::FETCH_WIDTH-1:0][31:0] imem_data,
  input  logic        resolve_valid,
  input  logic [63:0] resolve_pc,
  input  logic        resolve_taken,
  input  logic [63:0] resolve_target,
  input  logic        resolve_mispredict,
  output logic [63:0] next_pc_pred,
  fetch_bundle_if.pred_side pred
);

  localparam int FW        = frontend_pkg::FETCH_WIDTH;
  localparam int BHT_DEPTH = 2 ** BHT_INDEX_BITS;

  frontend_pkg::bht_state_e bht      [BHT_DEPTH];
  frontend_pkg::bht_state_e bht_next [BHT_DEPTH];
  logic [63:0]              btb      [BHT_DEPTH];
  logic [63:0]              btb_next [BHT_DEPTH];

  logic [FW-1:0][63:0]               lane_pc;
  logic [FW-1:0][BHT_INDEX_BITS-1:0] lane_idx;
  isa_pkg::branch_class_e            lane_class [FW];
  logic [FW-1:0]                     lane_taken;
  logic [BHT_INDEX_BITS-1:0]         res_idx;

  // one saturating step toward the resolved direction
  function automatic frontend_pkg::bht_state_e counter_step(
    input frontend_pkg::bht_state_e s,
    input logic                     taken
  );
    frontend_pkg::bht_state_e r;
    r = s;
    case (s)
      frontend_pkg::STRONG_NT: r = taken ? frontend_pkg::WEAK_NT  : frontend_pkg::STRONG_NT;
      frontend_pkg::WEAK_NT:   r = taken ? frontend_pkg::WEAK_T   : frontend_pkg::STRONG_NT;
      frontend_pkg::WEAK_T:    r = taken ? frontend_pkg::STRONG_T : frontend_pkg::WEAK_NT;
      frontend_pkg::STRONG_T:  r = taken ? frontend_pkg::STRONG_T : frontend_pkg::WEAK_T;
      default:                 r = frontend_pkg::BHT_RESET_STATE;
    endcase
    return r;
  endfunction

  assign res_idx = resolve_pc[BHT_INDEX_BITS+1:2];

  // resolution update, also used by this cycle's lookup
  always_comb begin
    bht_next = bht;
    btb_next = btb;
    if (resolve_valid) begin
      bht_next[res_idx] = counter_step(bht[res_idx], resolve_taken);
      // not-taken resolves leave the old target in place
      if (resolve_taken) begin
        btb_next[res_idx] = resolve_target;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < BHT_DEPTH; i++) begin
        bht[i] <= frontend_pkg::BHT_RESET_STATE;
        btb[i] <= '0;
      end
    end else begin
      bht <= bht_next;
      btb <= btb_next;
    end
  end

  // classify each lane and look up its direction
  always_comb begin
    for (int i = 0; i < FW; i++) begin
      lane_pc[i]  = fetch_pc + 64'(4 * i);
      lane_idx[i] = lane_pc[i][BHT_INDEX_BITS+1:2];
      case (isa_pkg::opcode_e'(imem_data[i][isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB]))
        isa_pkg::BLBC_INST, isa_pkg::BEQ_INST, isa_pkg::BLT_INST, isa_pkg::BLE_INST,
        isa_pkg::BLBS_INST, isa_pkg::BNE_INST, isa_pkg::BGE_INST, isa_pkg::BGT_INST:
          lane_class[i] = isa_pkg::BR_COND;
        isa_pkg::BR_INST, isa_pkg::BSR_INST, isa_pkg::JSR_GRP:
          lane_class[i] = isa_pkg::BR_UNCOND;
        default:
          lane_class[i] = isa_pkg::BR_NONE;
      endcase
      // counter msb is the direction
      lane_taken[i] = (lane_class[i] == isa_pkg::BR_UNCOND) ||
                      ((lane_class[i] == isa_pkg::BR_COND) && bht_next[lane_idx[i]][1]);
    end
  end

  // lane kill and next pc, first taken lane wins
  always_comb begin : steer
    logic found;
    found        = 1'b0;
    next_pc_pred = fetch_pc + 64'(4 * FW);
    for (int i = 0; i < FW; i++) begin
      // nothing goes out during rollback or without queue space
      pred.lane_valid[i] = fetch_enable && !resolve_mispredict && !found;
      pred.lane_entry[i].pc              = lane_pc[i];
      pred.lane_entry[i].instr           = imem_data[i];
      pred.lane_entry[i].predicted_taken = lane_taken[i];
      if (!found && lane_taken[i]) begin
        next_pc_pred = btb_next[lane_idx[i]];
        found        = 1'b1;
      end
    end
  end

  // wrong-path word behind a taken branch must not reach the queue
  a_lane_kill: assert property (
    @(posedge clock) disable iff (reset)
    pred.lane_valid[0] && pred.lane_entry[0].predicted_taken |-> !pred.lane_valid[1]
  ) else $error("lane 1 sent behind a taken lane 0");

endmodule

// File: hw/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
  parameter int QUEUE_DEPTH    = 8,
  parameter int DECODE_CREDITS = 2
) (
  input  logic        clock,
  input  logic        reset,
  fetch_bundle_if.queue_side q,
  input  logic        flush,
  input  logic        out_credit,
  output logic        out_valid,
  output logic [63:0] out_pc,
  output logic [31:0] out_instr,
  output logic        out_predicted_taken
);

  localparam int FW    = frontend_pkg::FETCH_WIDTH;
  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1) + 1;
  // spare bit so a wrapped counter reads above the limit
  localparam int DCR_W = $clog2(DECODE_CREDITS + 1) + 1;
  localparam int WR_W  = $clog2(FW + 1);

  frontend_pkg::fetch_entry_t mem [QUEUE_DEPTH];

  logic [PTR_W-1:0]  head;
  logic [PTR_W-1:0]  tail;
  logic [CNT_W-1:0]  count;
  logic [DCR_W-1:0]  down_credits;
  logic [WR_W-1:0]   wr_num;
  logic [PTR_W-1:0]  wr_ptr [FW];
  logic              deq;

  // circular increment, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_add(
    input logic [PTR_W-1:0] p,
    input int unsigned      n
  );
    int unsigned sum;
    sum = int'(p) + n;
    if (sum >= QUEUE_DEPTH) begin
      sum = sum - QUEUE_DEPTH;
    end
    return PTR_W'(sum);
  endfunction

  // valid lanes packed in lane order from the tail
  always_comb begin
    wr_num = '0;
    for (int i = 0; i < FW; i++) begin
      wr_ptr[i] = ptr_add(tail, int'(wr_num));
      wr_num    = wr_num + WR_W'(q.lane_valid[i]);
    end
  end

  // one entry per cycle, only with a decode slot in hand
  assign out_valid           = (count != '0) && (down_credits != '0) && !flush;
  assign deq                 = out_valid;
  assign out_pc              = mem[head].pc;
  assign out_instr           = mem[head].instr;
  assign out_predicted_taken = mem[head].predicted_taken;

  // slot freed on read, flush credits are restored by the pc stage
  assign q.credit_return = 2'(deq);

  always_ff @(posedge clock) begin
    for (int i = 0; i < FW; i++) begin
      if (q.lane_valid[i] && !flush) begin
        mem[wr_ptr[i]] <= q.lane_entry[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      down_credits <= DCR_W'(DECODE_CREDITS);
    end else begin
      if (flush) begin
        head  <= '0;
        tail  <= '0;
        count <= '0;
      end else begin
        if (deq) begin
          head <= ptr_add(head, 1);
        end
        tail  <= ptr_add(tail, int'(wr_num));
        count <= count + CNT_W'(wr_num) - CNT_W'(deq);
      end
      // decode slots survive a flush
      down_credits <= down_credits - DCR_W'(deq) + DCR_W'(out_credit);
    end
  end

  // upstream credit gating must keep writes within the ring
  a_no_overflow: assert property (
    @(posedge clock) disable iff (reset)
    !flush |-> (count + CNT_W'(wr_num) <= CNT_W'(QUEUE_DEPTH) + CNT_W'(deq))
  ) else $error("fetch queue written past its depth");

  // decode must not return more slots than it was given
  a_down_credit: assert property (
    @(posedge clock) disable iff (reset)
    down_credits <= DCR_W'(DECODE_CREDITS)
  ) else $error("decode credit count out of range");

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
  parameter int          BHT_INDEX_BITS = 4,
  parameter int          QUEUE_DEPTH    = 8,
  parameter int          DECODE_CREDITS = 2,
  parameter logic [63:0] RESET_PC       = 64'h0
) (
  input  logic        clock,
  input  logic        reset,
  output logic [frontend_pkg::FETCH_WIDTH-1:0][63:0] imem_addr,
  input  logic [frontend_pkg::FETCH_WIDTH-1:0][31:0] imem_data,
  output logic        out_valid,
  output logic [63:0] out_pc,
  output logic [31:0] out_instr,
  output logic        out_predicted_taken,
  input  logic        out_credit,
  input  logic        resolve_valid,
  input  logic [63:0] resolve_pc,
  input  logic        resolve_taken,
  input  logic [63:0] resolve_target,
  input  logic        resolve_mispredict
);

  logic [63:0] fetch_pc;
  logic [63:0] next_pc_pred;
  logic [63:0] redirect_pc;
  logic        fetch_enable;

  fetch_bundle_if bundle_if ();

  // restart at the resolved target, or just past the branch
  assign redirect_pc = resolve_taken ? resolve_target : resolve_pc + 64'd4;

  // consecutive words for each lane
  always_comb begin
    for (int i = 0; i < frontend_pkg::FETCH_WIDTH; i++) begin
      imem_addr[i] = fetch_pc + 64'(4 * i);
    end
  end

  fetch_pc_stage #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .RESET_PC    (RESET_PC)
  ) fetch_pc_stage_inst (
    .clock          (clock),
    .reset          (reset),
    .next_pc_pred   (next_pc_pred),
    .redirect_valid (resolve_mispredict),
    .redirect_pc    (redirect_pc),
    .pred           (bundle_if.pred_side),
    .fetch_pc       (fetch_pc),
    .fetch_enable   (fetch_enable)
  );

  branch_predictor #(
    .BHT_INDEX_BITS (BHT_INDEX_BITS)
  ) branch_predictor_inst (
    .clock              (clock),
    .reset              (reset),
    .fetch_pc           (fetch_pc),
    .fetch_enable       (fetch_enable),
    .imem_data          (imem_data),
    .resolve_valid      (resolve_valid),
    .resolve_pc         (resolve_pc),
    .resolve_taken      (resolve_taken),
    .resolve_target     (resolve_target),
    .resolve_mispredict (resolve_mispredict),
    .next_pc_pred       (next_pc_pred),
    .pred               (bundle_if.pred_side)
  );

  // mispredict empties the queue in the same cycle as the redirect
  fetch_queue #(
    .QUEUE_DEPTH    (QUEUE_DEPTH),
    .DECODE_CREDITS (DECODE_CREDITS)
  ) fetch_queue_inst (
    .clock               (clock),
    .reset               (reset),
    .q                   (bundle_if.queue_side),
    .flush               (resolve_mispredict),
    .out_credit          (out_credit),
    .out_valid           (out_valid),
    .out_pc              (out_pc),
    .out_instr           (out_instr),
    .out_predicted_taken (out_predicted_taken)
  );

endmodule

// File: tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

  localparam int       NUM_TESTS = 7;
  localparam int       DEC_CRED  = 2;
  localparam int       TMO       = 400;

  // one row per test
  typedef struct {
    int          image;
    logic [63:0] start;
    int          n_train;
    logic [63:0] tr_pc;
    logic        tr_taken;
    logic [63:0] tr_target;
    int          n_first;
    logic        mis_en;
    logic [63:0] mis_pc;
    logic        mis_taken;
    logic [63:0] mis_target;
    int          n_total;
    logic        throttle;
  } row_t;

  logic             clock;
  logic             reset;
  logic [1:0][63:0] imem_addr;
  logic [1:0][31:0] imem_data;
  logic             out_valid;
  logic [63:0]      out_pc;
  logic [31:0]      out_instr;
  logic             out_predicted_taken;
  logic             out_credit;
  logic             resolve_valid;
  logic [63:0]      resolve_pc;
  logic             resolve_taken;
  logic [63:0]      resolve_target;
  logic             resolve_mispredict;

  row_t        rows [NUM_TESTS];
  logic [31:0] img [256];
  // reference predictor state
  int          m_bht [16];
  logic [63:0] m_btb [16];
  logic [63:0] exp_pc [$];
  logic [31:0] exp_instr [$];
  logic        exp_tk [$];
  int          errors;
  int          failed_tests;
  int          outstanding;
  int          got;
  logic        collecting;
  logic        throttle;

  fetch_top fetch_top_inst (
    .clock               (clock),
    .reset               (reset),
    .imem_addr           (imem_addr),
    .imem_data           (imem_data),
    .out_valid           (out_valid),
    .out_pc              (out_pc),
    .out_instr           (out_instr),
    .out_predicted_taken (out_predicted_taken),
    .out_credit          (out_credit),
    .resolve_valid       (resolve_valid),
    .resolve_pc          (resolve_pc),
    .resolve_taken       (resolve_taken),
    .resolve_target      (resolve_target),
    .resolve_mispredict  (resolve_mispredict)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // plain alu word, every address bit folded in
  function automatic logic [31:0] fill_word(input logic [63:0] a);
    logic [63:0] x;
    x = a ^ (a >> 26) ^ (a >> 52);
    return {6'h11, x[27:2]};
  endfunction

  function automatic logic [31:0] mem_word(input logic [63:0] a);
    if (a < 64'd1024) begin
      return img[a[9:2]];
    end
    return fill_word(a);
  endfunction

  // combinational instruction memory
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      imem_data[i] = mem_word(imem_addr[i]);
    end
  end

  function automatic int index_of(input logic [63:0] pc);
    return int'(pc[5:2]);
  endfunction

  // taken rule from opcode and counter
  function automatic logic model_taken(input logic [63:0] pc, input logic [31:0] w);
    logic [5:0] op;
    op = w[31:26];
    if (op == 6'h30 || op == 6'h34 || op == 6'h1a) begin
      return 1'b1;
    end
    return (op >= 6'h38) && (m_bht[index_of(pc)] >= 2);
  endfunction

  // predicted fetch stream, truncated to n entries
  task automatic gen_stream(input logic [63:0] start, input int n);
    logic [63:0] pc;
    logic        t;
    int          base;
    base = exp_pc.size();
    pc = start;
    while (exp_pc.size() < base + n) begin
      t = model_taken(pc, mem_word(pc));
      exp_pc.push_back(pc);
      exp_instr.push_back(mem_word(pc));
      exp_tk.push_back(t);
      if (t) begin
        pc = m_btb[index_of(pc)];
      end else begin
        t = model_taken(pc + 4, mem_word(pc + 4));
        exp_pc.push_back(pc + 4);
        exp_instr.push_back(mem_word(pc + 4));
        exp_tk.push_back(t);
        pc = t ? m_btb[index_of(pc + 4)] : pc + 8;
      end
    end
    while (exp_pc.size() > base + n) begin
      void'(exp_pc.pop_back());
      void'(exp_instr.pop_back());
      void'(exp_tk.pop_back());
    end
  endtask

  // saturating counter step plus btb write
  task automatic model_resolve(input logic [63:0] pc, input logic taken, input logic [63:0] tgt);
    int i;
    i = index_of(pc);
    if (taken) begin
      m_bht[i] = (m_bht[i] == 3) ? 3 : m_bht[i] + 1;
      m_btb[i] = tgt;
    end else begin
      m_bht[i] = (m_bht[i] == 0) ? 0 : m_bht[i] - 1;
    end
  endtask

  // sample at negedge, hand back decode credits at posedge
  task automatic cycle();
    @(negedge clock);
    if (out_valid) begin
      outstanding++;
      assert (outstanding <= DEC_CRED) else begin
        errors++;
        $display("** Error [%0t] out_valid beyond granted credits (%0d)", $time, outstanding);
      end
      if (collecting) begin
        assert (exp_pc.size() != 0) else begin
          errors++;
          $display("** Error [%0t] unexpected entry pc=%h", $time, out_pc);
        end
        if (exp_pc.size() != 0) begin
          assert (out_pc == exp_pc[0] && out_instr == exp_instr[0] &&
                  out_predicted_taken == exp_tk[0]) else begin
            errors++;
            $display("** Error [%0t] got pc=%h instr=%h tk=%b, expected pc=%h instr=%h tk=%b",
                     $time, out_pc, out_instr, out_predicted_taken,
                     exp_pc[0], exp_instr[0], exp_tk[0]);
          end
          void'(exp_pc.pop_front());
          void'(exp_instr.pop_front());
          void'(exp_tk.pop_front());
          got++;
        end
      end
    end
    @(posedge clock);
    if (outstanding > 0 && (!throttle || ($urandom % 4) == 0)) begin
      out_credit <= 1'b1;
      outstanding--;
    end else begin
      out_credit <= 1'b0;
    end
  endtask

  task automatic drive_resolve(input logic v, input logic [63:0] pc, input logic tk,
                               input logic [63:0] tgt, input logic mis);
    resolve_valid      <= v;
    resolve_pc         <= pc;
    resolve_taken      <= tk;
    resolve_target     <= tgt;
    resolve_mispredict <= mis;
  endtask

  task automatic load_image(input int sel);
    for (int i = 0; i < 256; i++) begin
      img[i] = fill_word(64'(i * 4));
    end
    // beq at 0x40, br at 0x80
    if (sel == 1) img[16] = {6'h39, 26'h0000123};
    if (sel == 2) img[32] = {6'h30, 26'h0000456};
  endtask

  task automatic run_test(input int n);
    row_t r;
    int   tmo;
    int   err0;
    logic fired;
    logic pending;
    r = rows[n];
    err0 = errors;
    throttle = r.throttle;
    load_image(r.image);
    for (int k = 0; k < r.n_train; k++) begin
      drive_resolve(1'b1, r.tr_pc, r.tr_taken, r.tr_target, 1'b0);
      cycle();
      drive_resolve(1'b0, 64'h0, 1'b0, 64'h0, 1'b0);
      model_resolve(r.tr_pc, r.tr_taken, r.tr_target);
      cycle();
    end
    // plain redirect to the start pc, queue flushed
    drive_resolve(1'b0, 64'h0, 1'b1, r.start, 1'b1);
    cycle();
    drive_resolve(1'b0, 64'h0, 1'b0, 64'h0, 1'b0);
    exp_pc.delete();
    exp_instr.delete();
    exp_tk.delete();
    gen_stream(r.start, r.mis_en ? r.n_first : r.n_total);
    got = 0;
    fired = 1'b0;
    pending = 1'b0;
    collecting = 1'b1;
    tmo = 0;
    while (got < r.n_total && tmo < TMO) begin
      cycle();
      tmo++;
      if (pending) begin
        drive_resolve(1'b0, 64'h0, 1'b0, 64'h0, 1'b0);
        pending = 1'b0;
      end
      if (r.mis_en && !fired && got == r.n_first) begin
        drive_resolve(1'b1, r.mis_pc, r.mis_taken, r.mis_target, 1'b1);
        model_resolve(r.mis_pc, r.mis_taken, r.mis_target);
        gen_stream(r.mis_taken ? r.mis_target : r.mis_pc + 4, r.n_total - r.n_first);
        fired = 1'b1;
        pending = 1'b1;
      end
    end
    if (pending) drive_resolve(1'b0, 64'h0, 1'b0, 64'h0, 1'b0);
    collecting = 1'b0;
    if (got < r.n_total) begin
      errors++;
      $display("timeout in test %0d: only %0d of %0d entries reached decode", n, got, r.n_total);
    end
    if (errors == err0) begin
      $display("test %0d ok, %0d entries checked", n, got);
    end else begin
      failed_tests++;
      $display("test %0d failed with %0d errors", n, errors - err0);
    end
  endtask

  initial begin
    reset = 1'b1;
    out_credit = 1'b0;
    resolve_valid = 1'b0;
    resolve_pc = '0;
    resolve_taken = 1'b0;
    resolve_target = '0;
    resolve_mispredict = 1'b0;
    errors = 0;
    failed_tests = 0;
    outstanding = 0;
    collecting = 1'b0;
    throttle = 1'b0;
    void'($urandom(32'ha28d));
    for (int i = 0; i < 16; i++) begin
      m_bht[i] = 1;
      m_btb[i] = '0;
    end
    load_image(0);
    // image, start, train x4, mispredict x5, total, throttle
    rows[0] = '{0, 64'h0,  0, 64'h0,  1'b0, 64'h0,   0, 1'b0, 64'h0,   1'b0, 64'h0,   12, 1'b0};
    rows[1] = '{1, 64'h30, 0, 64'h0,  1'b0, 64'h0,   0, 1'b0, 64'h0,   1'b0, 64'h0,   10, 1'b0};
    rows[2] = '{1, 64'h30, 2, 64'h40, 1'b1, 64'h200, 0, 1'b0, 64'h0,   1'b0, 64'h0,   10, 1'b0};
    rows[3] = '{1, 64'h30, 2, 64'h40, 1'b0, 64'h0,   0, 1'b0, 64'h0,   1'b0, 64'h0,   10, 1'b0};
    rows[4] = '{2, 64'h70, 1, 64'h80, 1'b1, 64'h300, 0, 1'b0, 64'h0,   1'b0, 64'h0,   10, 1'b0};
    rows[5] = '{0, 64'h0,  0, 64'h0,  1'b0, 64'h0,   5, 1'b1, 64'h10,  1'b1, 64'h100, 12, 1'b0};
    rows[6] = '{2, 64'h70, 0, 64'h0,  1'b0, 64'h0,   6, 1'b1, 64'h300, 1'b0, 64'h0,   14, 1'b1};
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    for (int n = 0; n < NUM_TESTS; n++) begin
      run_test(n);
    end
    $display("tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
hw/isa_pkg.sv
hw/frontend_pkg.sv
hw/fetch_bundle_if.sv
hw/fetch_pc_stage.sv
hw/branch_predictor.sv
hw/fetch_queue.sv
hw/fetch_top.sv
tests/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module fetch_tb --Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

output=$(./obj_dir/fetch_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1
